// File: Makefile
# Verilator build and run of the squarer testbench
TOP := tb_modsq

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 -f files.f --top-module $(TOP) -o V$(TOP)

# Pass only if the testbench printed its pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: files.f
+incdir+src
+incdir+test
src/modsq_pkg.sv
src/iter_ctrl_if.sv
src/compressor_tree.sv
src/carry_normalize.sv
src/iteration_ctrl.sv
src/square_grid.sv
src/reduction_rom.sv
src/reduction_accum.sv
src/modsq_top.sv
test/tb_modsq.sv

// File: src/carry_normalize.sv
/* Partial carry normalization of carry/sum column pairs into 17-bit limbs.
   Each limb gets its own low word plus the bits above 16 of the column below */
`timescale 1ns/1ps
`include "modsq_defines.svh"

module carry_normalize import modsq_pkg::*; #(
   parameter int  NUM_COLS = 6,
   parameter type col_t    = logic [23:0]
) (
   input  col_t  c     [NUM_COLS],
   input  col_t  s     [NUM_COLS],
   output limb_t limbs [NUM_COLS]
);

   localparam int COL_BITS = $bits(col_t);
   localparam int WORD_LEN = `MODSQ_WORD_LEN;

   col_t col_sum [NUM_COLS];   // Column totals fit col_t, no extra bit

   always_comb begin
      for (int k = 0; k < NUM_COLS; k++) begin
         col_sum[k] = c[k] + s[k];
      end

      limbs[0] = limb_t'(col_sum[0][WORD_LEN-1:0]);   // Nothing comes from below

      for (int k = 1; k < NUM_COLS - 1; k++) begin
         limbs[k] = limb_t'(col_sum[k][WORD_LEN-1:0]) +
                    limb_t'(col_sum[k-1][COL_BITS-1:WORD_LEN]);
      end

      // Top column keeps its redundant bit
      limbs[NUM_COLS-1] = col_sum[NUM_COLS-1][`MODSQ_LIMB_BITS-1:0] +
                          limb_t'(col_sum[NUM_COLS-2][COL_BITS-1:WORD_LEN]);
   end

endmodule

// File: src/compressor_tree.sv
/* Carry-save reduction of one column of terms to a carry/sum pair.
   Used for square columns and accumulator columns alike */
`timescale 1ns/1ps

module compressor_tree #(
   parameter int  NUM_TERMS = 3,
   parameter type term_t    = logic [23:0]
) (
   input  term_t terms [NUM_TERMS],
   output term_t c,
   output term_t s
);

   generate
      if (NUM_TERMS == 1) begin : g_single
         assign c = '0;
         assign s = terms[0];
      end else begin : g_chain
         // Chain of 3:2 adders, each folds one more term into the pair
         always_comb begin
            term_t sum;
            term_t carry;
            term_t next_sum;

            sum      = terms[0];
            carry    = terms[1];
            next_sum = '0;
            for (int k = 2; k < NUM_TERMS; k++) begin
               next_sum = sum ^ carry ^ terms[k];
               // Majority bits move up one place
               carry    = ((sum & carry) | (sum & terms[k]) | (carry & terms[k])) << 1;
               sum      = next_sum;
            end

            // Top carry bit is never lost while the column total fits term_t
            c = carry;
            s = sum;
         end
      end
   endgenerate

endmodule

// File: src/iter_ctrl_if.sv
/* Operand and phase strobes from the sequencer to the three datapath stages.
   The sequencer drives the ctrl side, each stage listens on the stage side */
`timescale 1ns/1ps

interface iter_ctrl_if import modsq_pkg::*; ();

   limb_vec_t operand;      // Captured input or looped-back result
   logic      phase_grid;   // Square grid settles, registered at the end
   logic      phase_lut;    // ROM read of the upper square limbs
   logic      phase_out;    // Accumulate and load sq_out

   modport ctrl (
      output operand,
      output phase_grid,
      output phase_lut,
      output phase_out
   );

   modport stage (
      input operand,
      input phase_grid,
      input phase_lut,
      input phase_out
   );

endinterface

// File: src/iteration_ctrl.sv
/* Phase sequencer of the squarer. Captures sq_in on start, then rotates the
   grid, lut and out strobes and picks the operand for each squaring */
`timescale 1ns/1ps

module iteration_ctrl import modsq_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  limb_vec_t sq_in,
   input  limb_vec_t sq_out,    // Loopback from the accumulator
   iter_ctrl_if.ctrl ctrl
);

   localparam int IDLE = 0;
   localparam int GRID = 1;
   localparam int LUT  = 2;
   localparam int OUT  = 3;

   logic [3:0] curr_phase;   // One-hot
   logic [3:0] next_phase;
   logic       start_pending;
   limb_vec_t  sq_in_reg;

   // A start restarts from the grid phase whatever is in flight
   always_comb begin
      next_phase = '0;
      if (start)                 next_phase[GRID] = 1'b1;
      else if (curr_phase[IDLE]) next_phase[IDLE] = 1'b1;
      else if (curr_phase[GRID]) next_phase[LUT]  = 1'b1;
      else if (curr_phase[LUT])  next_phase[OUT]  = 1'b1;
      else                       next_phase[GRID] = 1'b1;   // Out wraps to grid
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         curr_phase    <= 4'b0001;
         start_pending <= 1'b0;
      end else begin
         curr_phase    <= next_phase;
         start_pending <= start | (start_pending & ~curr_phase[OUT]);   // Until first result
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         sq_in_reg <= sq_in;
      end
   end

   assign ctrl.operand    = start_pending ? sq_in_reg : sq_out;
   assign ctrl.phase_grid = curr_phase[GRID];
   assign ctrl.phase_lut  = curr_phase[LUT];
   assign ctrl.phase_out  = curr_phase[OUT];

endmodule

// File: src/modsq_defines.svh
/* Width, count and modulus macros for the iterated modular squarer.
   Included by the package and by each module that sizes ports or loops from them */
`ifndef MODSQ_DEFINES_SVH
`define MODSQ_DEFINES_SVH

// Limb format, weight 2^16 with one redundant bit per limb
`define MODSQ_WORD_LEN         16
`define MODSQ_LIMB_BITS        17

// Four limbs span the modulus, two more absorb growth
`define MODSQ_NONRED_LIMBS     4
`define MODSQ_REDUNDANT_LIMBS  2
`define MODSQ_NUM_LIMBS        (`MODSQ_NONRED_LIMBS + `MODSQ_REDUNDANT_LIMBS)

// Reduction lookups split each upper limb into 8 low and 9 high bits
`define MODSQ_LUT_LOW_BITS     8
`define MODSQ_LUT_ADDR_BITS    9

`define MODSQ_GRID_COL_BITS    24   // Up to six 19-bit terms per square column
`define MODSQ_ACC_COL_BITS     24   // Seventeen terms per accumulator column

`define MODSQ_MODULUS          64'hC2E75A9B1F3D8867

`endif

// File: src/modsq_pkg.sv
/* Shared limb, column and ROM types of the squarer, plus the function that
   computes each reduction ROM entry. Modules take it by a wildcard import */
`include "modsq_defines.svh"

package modsq_pkg;

   // One stored limb, weight 2^(16*i) for limb i
   typedef logic [`MODSQ_LIMB_BITS-1:0] limb_t;

   // Whole operand or result, limb 0 in the low bits
   typedef limb_t [`MODSQ_NUM_LIMBS-1:0] limb_vec_t;

   typedef logic [`MODSQ_GRID_COL_BITS-1:0] grid_col_t;   // Square column term
   typedef logic [`MODSQ_ACC_COL_BITS-1:0]  acc_col_t;    // Accumulator column term

   typedef logic [`MODSQ_LUT_ADDR_BITS-1:0] rom_addr_t;

   // Residue below N, read back as four 16-bit words
   typedef logic [`MODSQ_NONRED_LIMBS*`MODSQ_WORD_LEN-1:0] rom_word_t;

   /* Value of addr placed at limb col, shifted up 8 more bits for the high
      half, reduced modulo N */
   function automatic rom_word_t reduction_entry(input int        col,
                                                 input int        half,
                                                 input rom_addr_t addr);
      logic [127:0] modulus;
      logic [127:0] weight;
      logic [127:0] product;

      modulus = 128'(`MODSQ_MODULUS);
      weight  = 128'd1;

      // Weight of the column, 2^(16*col) mod N, one limb step at a time
      for (int k = 0; k < col; k++) begin
         weight = (weight << `MODSQ_WORD_LEN) % modulus;
      end

      if (half != 0) begin
         weight = (weight << `MODSQ_LUT_LOW_BITS) % modulus;   // High 9-bit slice
      end

      // Address below 2^9 and weight below N keep this under 2^73
      product = (128'(addr) * weight) % modulus;
      return rom_word_t'(product);
   endfunction

endpackage

// File: src/modsq_top.sv
/* Top level of the iterated modular squarer. Start captures sq_in, and each
   finished squaring appears on sq_out with a one-cycle valid pulse */
`timescale 1ns/1ps
`include "modsq_defines.svh"

module modsq_top import modsq_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  limb_vec_t sq_in,
   output limb_vec_t sq_out,
   output logic      valid
);

   limb_t     lower [`MODSQ_NONRED_LIMBS];                        // Square limbs 0..3
   limb_t     upper [2*`MODSQ_NUM_LIMBS-`MODSQ_NONRED_LIMBS];     // Square limbs 4..11
   rom_word_t words [4*`MODSQ_NUM_LIMBS-2*`MODSQ_NONRED_LIMBS];   // ROM read data

   iter_ctrl_if ctrl_bus ();

   iteration_ctrl u_iteration_ctrl (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .sq_in  (sq_in),
      .sq_out (sq_out),
      .ctrl   (ctrl_bus)
   );

   square_grid u_square_grid (.clk(clk), .bus(ctrl_bus), .lower(lower), .upper(upper));

   reduction_rom u_reduction_rom (.clk(clk), .bus(ctrl_bus), .upper(upper), .words(words));

   reduction_accum u_reduction_accum (
      .clk    (clk),
      .reset  (reset),
      .bus    (ctrl_bus),
      .lower  (lower),
      .words  (words),
      .sq_out (sq_out),
      .valid  (valid)
   );

endmodule

// File: src/reduction_accum.sv
/* Final accumulation. Adds the lower square limbs to every ROM word of the
   same weight, normalizes, loads sq_out on phase_out and pulses valid */
`timescale 1ns/1ps
`include "modsq_defines.svh"

module reduction_accum import modsq_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   iter_ctrl_if.stage        bus,
   input  limb_t             lower [`MODSQ_NONRED_LIMBS],
   input  rom_word_t         words [4*`MODSQ_NUM_LIMBS-2*`MODSQ_NONRED_LIMBS],
   output limb_vec_t         sq_out,
   output logic              valid
);

   localparam int NUM_LIMBS = `MODSQ_NUM_LIMBS;
   localparam int NONRED    = `MODSQ_NONRED_LIMBS;
   localparam int NUM_ROMS  = 4 * NUM_LIMBS - 2 * NONRED;
   localparam int WORD_LEN  = `MODSQ_WORD_LEN;

   acc_col_t acc_c      [NUM_LIMBS];
   acc_col_t acc_s      [NUM_LIMBS];
   limb_t    norm_limbs [NUM_LIMBS];

   for (genvar k = 0; k < NONRED; k++) begin : g_col
      acc_col_t terms [NUM_ROMS + 1];

      always_comb begin
         terms[0] = acc_col_t'(lower[k]);
         for (int r = 0; r < NUM_ROMS; r++) begin
            terms[r + 1] = acc_col_t'(words[r][k*WORD_LEN +: WORD_LEN]);   // Word k
         end
      end

      compressor_tree #(.NUM_TERMS(NUM_ROMS + 1), .term_t(acc_col_t)) u_tree (
         .terms (terms),
         .c     (acc_c[k]),
         .s     (acc_s[k])
      );
   end

   // Redundant limbs only collect carries from below
   for (genvar k = NONRED; k < NUM_LIMBS; k++) begin : g_empty
      assign acc_c[k] = '0;
      assign acc_s[k] = '0;
   end

   carry_normalize #(.NUM_COLS(NUM_LIMBS), .col_t(acc_col_t)) u_normalize (
      .c     (acc_c),
      .s     (acc_s),
      .limbs (norm_limbs)
   );

   always_ff @(posedge clk) begin
      if (bus.phase_out) begin
         for (int k = 0; k < NUM_LIMBS; k++) sq_out[k] <= norm_limbs[k];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) valid <= 1'b0;
      else       valid <= bus.phase_out;   // One cycle, with the new sq_out
   end

endmodule

// File: src/reduction_rom.sv
/* Reduction ROMs for square limbs 4 to 11. Each limb addresses one ROM with
   its low 8 bits and one with its high 9 bits, read data held after phase_lut */
`timescale 1ns/1ps
`include "modsq_defines.svh"

module reduction_rom import modsq_pkg::*; (
   input  logic              clk,
   iter_ctrl_if.stage        bus,
   input  limb_t             upper [2*`MODSQ_NUM_LIMBS-`MODSQ_NONRED_LIMBS],
   output rom_word_t         words [4*`MODSQ_NUM_LIMBS-2*`MODSQ_NONRED_LIMBS]
);

   localparam int NUM_UPPER = 2 * `MODSQ_NUM_LIMBS - `MODSQ_NONRED_LIMBS;
   localparam int NUM_ROMS  = 2 * NUM_UPPER;   // Even entries low half, odd high
   localparam int ROM_DEPTH = 2 ** `MODSQ_LUT_ADDR_BITS;

   for (genvar r = 0; r < NUM_ROMS; r++) begin : g_rom
      localparam int COL  = `MODSQ_NONRED_LIMBS + r / 2;   // Square limb index
      localparam int HALF = r % 2;

      rom_word_t rom [ROM_DEPTH];
      rom_addr_t addr;

      if (HALF == 0) begin : g_low
         assign addr = rom_addr_t'(upper[r/2][`MODSQ_LUT_LOW_BITS-1:0]);
      end else begin : g_high
         assign addr = upper[r/2][`MODSQ_LIMB_BITS-1:`MODSQ_LUT_LOW_BITS];
      end

      // Multiples of 2^(16*COL + 8*HALF) mod N
      initial begin
         for (int a = 0; a < ROM_DEPTH; a++) begin
            rom[a] = reduction_entry(COL, HALF, rom_addr_t'(a));
         end
      end

      always_ff @(posedge clk) begin
         if (bus.phase_lut) begin
            words[r] <= rom[addr];   // Synchronous read
         end
      end
   end

endmodule

// File: src/square_grid.sv
/* Squaring stage. Forms the upper-triangular product grid of the operand,
   sums each column and holds the normalized square limbs after phase_grid */
`timescale 1ns/1ps
`include "modsq_defines.svh"

module square_grid import modsq_pkg::*; (
   input  logic              clk,
   iter_ctrl_if.stage        bus,
   output limb_t             lower [`MODSQ_NONRED_LIMBS],
   output limb_t             upper [2*`MODSQ_NUM_LIMBS-`MODSQ_NONRED_LIMBS]
);

   localparam int NUM_LIMBS = `MODSQ_NUM_LIMBS;
   localparam int NONRED    = `MODSQ_NONRED_LIMBS;
   localparam int NUM_COLS  = 2 * NUM_LIMBS;
   localparam int WORD_LEN  = `MODSQ_WORD_LEN;
   localparam int PROD_BITS = 2 * `MODSQ_LIMB_BITS + 1;   // Room for the doubling

   logic [PROD_BITS-1:0] prod       [NUM_LIMBS][NUM_LIMBS];
   grid_col_t            col_c      [NUM_COLS];
   grid_col_t            col_s      [NUM_COLS];
   limb_t                norm_limbs [NUM_COLS];
   limb_t                grid_reg   [NUM_COLS];

   // Number of products a_i*a_j with i <= j and i + j == idx
   function automatic int pair_count(input int idx);
      int n;
      n = 0;
      for (int i = 0; i < NUM_LIMBS; i++) begin
         if ((idx - i >= i) && (idx - i < NUM_LIMBS)) n = n + 1;
      end
      return n;
   endfunction

   always_comb begin
      for (int i = 0; i < NUM_LIMBS; i++) begin
         for (int j = 0; j < NUM_LIMBS; j++) begin
            if (j == i)
               prod[i][j] = PROD_BITS'(bus.operand[i]) * PROD_BITS'(bus.operand[j]);
            else if (j > i)   // Stands for both a_i*a_j and a_j*a_i
               prod[i][j] = (PROD_BITS'(bus.operand[i]) * PROD_BITS'(bus.operand[j])) << 1;
            else
               prod[i][j] = '0;
         end
      end
   end

   for (genvar col = 0; col < NUM_COLS; col++) begin : g_col
      if (col == 0) begin : g_first
         assign col_c[col] = '0;
         assign col_s[col] = grid_col_t'(prod[0][0][WORD_LEN-1:0]);
      end else begin : g_tree
         localparam int N_TERMS = pair_count(col) + pair_count(col - 1);
         grid_col_t terms [N_TERMS];

         // Low words of this column's products, high parts of the column below
         always_comb begin
            int idx;
            idx = 0;
            for (int i = 0; i < NUM_LIMBS; i++) begin
               for (int j = i; j < NUM_LIMBS; j++) begin
                  if (i + j == col) begin
                     terms[idx] = grid_col_t'(prod[i][j][WORD_LEN-1:0]);
                     idx = idx + 1;
                  end
                  if (i + j + 1 == col) begin
                     terms[idx] = grid_col_t'(prod[i][j][PROD_BITS-1:WORD_LEN]);
                     idx = idx + 1;
                  end
               end
            end
         end

         compressor_tree #(.NUM_TERMS(N_TERMS), .term_t(grid_col_t)) u_tree (
            .terms (terms),
            .c     (col_c[col]),
            .s     (col_s[col])
         );
      end
   end

   carry_normalize #(.NUM_COLS(NUM_COLS), .col_t(grid_col_t)) u_normalize (
      .c     (col_c),
      .s     (col_s),
      .limbs (norm_limbs)
   );

   always_ff @(posedge clk) begin
      if (bus.phase_grid) grid_reg <= norm_limbs;   // Held through lut and out
   end

   always_comb begin
      for (int k = 0; k < NONRED; k++) lower[k] = grid_reg[k];
      for (int k = 0; k < NUM_COLS - NONRED; k++) upper[k] = grid_reg[k + NONRED];
   end

endmodule

// File: test/tb_modsq_checks.svh
/* Reference model and compare tasks for the squarer testbench.
   Included inside tb_modsq, which owns the error counter */
`ifndef TB_MODSQ_CHECKS_SVH
`define TB_MODSQ_CHECKS_SVH

localparam logic [127:0] MODULUS_WIDE = 128'(`MODSQ_MODULUS);

// Value of a limb vector, limb i weighted by 2^(16*i)
function automatic logic [127:0] limbs_to_int(input limb_vec_t v);
   logic [127:0] acc;
   acc = '0;
   for (int i = `MODSQ_NUM_LIMBS - 1; i >= 0; i--) begin
      acc = (acc << `MODSQ_WORD_LEN) + 128'(v[i]);
   end
   return acc;
endfunction

// x^(2^k) mod N, by k successive squarings
function automatic logic [63:0] square_iterated(input logic [127:0] x, input int k);
   logic [127:0] r;
   r = x % MODULUS_WIDE;
   for (int i = 0; i < k; i++) begin
      r = (r * r) % MODULUS_WIDE;   // r < 2^64 so the product fits
   end
   return r[63:0];
endfunction

task automatic check_residue(input limb_vec_t got, input logic [63:0] expected);
   logic [127:0] residue;
   residue = limbs_to_int(got) % MODULUS_WIDE;
   if (residue[63:0] !== expected) begin
      $display("ERR sq_out: got %h, residue %h, expected residue %h",
               got, residue[63:0], expected);
      errors = errors + 1;
   end
endtask

task automatic check_valid(input logic got, input logic expected);
   if (got !== expected) begin
      $display("ERR valid: got %h, expected %h", got, expected);
      errors = errors + 1;
   end
endtask

// Cycles between start or the previous pulse and a valid pulse
task automatic check_latency(input int got, input int expected);
   if (got != expected) begin
      $display("ERR valid latency: got %0h cycles, expected %0h", got, expected);
      errors = errors + 1;
   end
endtask

`endif

// File: test/tb_modsq.sv
/* Directed testbench for the iterated modular squarer. Checks idle after
   reset, start latency, iteration, redundant inputs and restart */
`timescale 1ns/1ps
`include "modsq_defines.svh"

module tb_modsq import modsq_pkg::*; ();

   localparam int CLK_PERIOD      = 100;
   localparam int RESET_CYCLES    = 8;
   localparam int NUM_TESTS       = 5;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + 100;
   localparam int START_LATENCY   = 4;    // Start drive edge to first valid sample
   localparam int ITER_PERIOD     = 3;
   localparam int MAX_WAIT        = 20;
   localparam int NUM_ITERS       = 6;

   logic      clk;
   logic      reset;
   logic      start;
   limb_vec_t sq_in;
   limb_vec_t sq_out;
   logic      valid;

   int errors;
   int tests_run;
   int tests_failed;

`include "tb_modsq_checks.svh"

   modsq_top u_modsq_top (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .sq_in  (sq_in),
      .sq_out (sq_out),
      .valid  (valid)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout, run went past %0d clock cycles", WATCHDOG_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // Places an operand below 2^64 in the four low limbs with zero redundant limbs
   function automatic limb_vec_t to_limbs(input logic [63:0] x);
      limb_vec_t v;
      v = '0;
      for (int k = 0; k < `MODSQ_NONRED_LIMBS; k++) begin
         v[k] = limb_t'(x[k*`MODSQ_WORD_LEN +: `MODSQ_WORD_LEN]);
      end
      return v;
   endfunction

   function automatic logic [63:0] random_residue();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r % `MODSQ_MODULUS;
   endfunction

   // One-cycle start pulse that ends on the next falling edge
   task automatic start_item(input limb_vec_t x);
      @(negedge clk);
      sq_in = x;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic wait_for_valid(input int cycles_done, output int cycles);
      cycles = cycles_done;
      do begin
         @(negedge clk);
         cycles = cycles + 1;
      end while (valid !== 1'b1 && cycles < MAX_WAIT);
      if (valid !== 1'b1) begin
         $display("valid did not arrive within %0d cycles", MAX_WAIT);
         errors = errors + 1;
      end
   endtask

   task automatic square_once(input limb_vec_t x, input logic [63:0] expected);
      int cycles;
      start_item(x);
      wait_for_valid(1, cycles);
      check_latency(cycles, START_LATENCY);
      check_residue(sq_out, expected);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run = tests_run + 1;
      if (errors == errors_before) begin
         $display("%s: passed", name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("%s: failed with %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic stay_idle_after_reset();
      int errors_before;
      errors_before = errors;
      repeat (10) begin
         @(negedge clk);
         check_valid(valid, 1'b0);
      end
      finish_test("idle after reset", errors_before);
   endtask

   task automatic small_operand_square();
      int errors_before;
      errors_before = errors;
      square_once(to_limbs(64'd3), 64'd9);
      finish_test("small operand", errors_before);
   endtask

   task automatic iterate_random_operand();
      int          errors_before;
      int          cycles;
      logic [63:0] x;
      errors_before = errors;
      x = random_residue();
      start_item(to_limbs(x));
      for (int k = 1; k <= NUM_ITERS; k++) begin
         wait_for_valid((k == 1) ? 1 : 0, cycles);
         check_latency(cycles, (k == 1) ? START_LATENCY : ITER_PERIOD);
         check_residue(sq_out, square_iterated(128'(x), k));
      end
      finish_test("iteration", errors_before);
   endtask

   task automatic redundant_input_square();
      int        errors_before;
      limb_vec_t x;
      errors_before = errors;

      // Limbs at their 17-bit maximum with a top limb that keeps the value under 2^96
      for (int k = 0; k < `MODSQ_NUM_LIMBS - 1; k++) begin
         x[k] = 17'h1ffff;
      end
      x[`MODSQ_NUM_LIMBS-1] = 17'h07fff;
      square_once(x, square_iterated(limbs_to_int(x), 1));

      for (int k = 0; k < `MODSQ_NUM_LIMBS - 1; k++) begin
         x[k] = limb_t'($urandom()) | 17'h10000;   // Bit 16 always set
      end
      x[`MODSQ_NUM_LIMBS-1] = limb_t'($urandom() & 32'h7fff) | 17'h00001;
      square_once(x, square_iterated(limbs_to_int(x), 1));
      finish_test("redundant input", errors_before);
   endtask

   task automatic restart_mid_iteration();
      int          errors_before;
      int          cycles;
      logic [63:0] x_old;
      logic [63:0] x_new;
      errors_before = errors;
      x_old = random_residue();
      x_new = random_residue();
      start_item(to_limbs(x_old));
      for (int k = 1; k <= 2; k++) begin
         wait_for_valid((k == 1) ? 1 : 0, cycles);
         check_latency(cycles, (k == 1) ? START_LATENCY : ITER_PERIOD);
         check_residue(sq_out, square_iterated(128'(x_old), k));
      end
      // New start lands in the lut phase of the third squaring
      square_once(to_limbs(x_new), square_iterated(128'(x_new), 1));
      finish_test("restart", errors_before);
   endtask

   initial begin
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      reset        = 1'b1;
      start        = 1'b0;
      sq_in        = '0;
      void'($urandom(32'hb241b3da));

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      stay_idle_after_reset();
      small_operand_square();
      iterate_random_operand();
      redundant_input_square();
      restart_mid_iteration();

      $display("tests run %0d, failed %0d, check errors %0d",
               tests_run, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
